//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= game_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/game_tb.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module game_tb;

    localparam int RESET_CYCLES   = 5;
    localparam int RUN_FRAMES     = 40;
    localparam int RANDOM_FRAMES  = 6;   // after these the player is steered onto lava
    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_CYCLES = RUN_FRAMES * FRAME_CYCLES + 1000 + RESET_CYCLES;
    localparam int X_MAX          = `H_ACTIVE - `PLAYER_SIZE;
    localparam int Y_MAX          = `V_ACTIVE - `PLAYER_SIZE;
    localparam int TARGET_X       = 52;  // tile column 6 is lava on the clamped bottom row

    logic       clk = 1'b0;
    logic       rst;
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [3:0] pix;
    logic       hsync;
    logic       vsync;
    logic       blank;
    logic [3:0] hp;

    logic [31:0]         seed;              // LCG state
    int                  cycle_cnt = 0;     // counts every clock for the timeout
    int                  frame_idx;
    int                  cyc;               // cycles since reset release
    int                  prev_hp;
    int                  hp_seen;           // hp one cycle back, the value pix was built from
    int                  last_drop;
    int                  drops;
    int                  m_h;               // model scan counters
    int                  m_v;
    int                  m_px;              // model anchor
    int                  m_py;
    int                  m_cur;             // model sampled tile code
    game_pkg::hp_state_t m_state;
    int                  m_hp;
    int                  m_hold;            // cycles already spent in hold
    int                  m_pix;             // model output register
    bit                  m_hs;
    bit                  m_vs;
    bit                  m_blank;

    game_top dut (
        .clk(clk), .rst(rst), .up(up), .down(down), .left(left), .right(right),
        .pix(pix), .hsync(hsync), .vsync(vsync), .blank(blank), .hp(hp)
    );

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // lava where the low two bits of tile_x xor tile_y are both set and grass or sand elsewhere
    function automatic int tile_code(input int h, input int v);
        int tx;
        int ty;
        tx = h >> `TILE_SHIFT;
        ty = v >> `TILE_SHIFT;
        if (((tx ^ ty) & 3) == 3) return int'(game_pkg::C_LAVA);
        if ((ty & 1) == 1) return int'(game_pkg::C_SAND);  // odd tile rows
        return int'(game_pkg::C_GRASS);
    endfunction

    task automatic compare_value(input string name, input int exp_v, input int act_v);
        assert (act_v == exp_v) else begin
            $display("[FAIL] %s expected %0h got %0h", name, exp_v, act_v);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic model_reset();
        m_h     = 0;
        m_v     = 0;
        m_px    = `PLAYER_X0;
        m_py    = `PLAYER_Y0;
        m_cur   = int'(game_pkg::C_GRASS);
        m_state = game_pkg::HP_IDLE;
        m_hp    = `HP_INIT;
        m_hold  = 0;
        m_pix   = int'(game_pkg::C_BLACK);
        m_hs    = 1'b0;
        m_vs    = 1'b0;
        m_blank = 1'b1;  // dark until the first real pixel
    endtask

    // one rising edge of the whole game where every next value comes from the current state
    task automatic model_step();
        int                  code;
        int                  pix_c;
        int                  px_n;
        int                  py_n;
        int                  cur_n;
        int                  hp_n;
        int                  hold_n;
        game_pkg::hp_state_t st_n;
        bit                  blank_c;
        bit                  in_player;
        bit                  in_bar;
        code      = tile_code(m_h, m_v);
        blank_c   = (m_h >= `H_ACTIVE) || (m_v >= `V_ACTIVE);
        in_player = (m_h >= m_px) && (m_h < m_px + `PLAYER_SIZE) &&
                    (m_v >= m_py) && (m_v < m_py + `PLAYER_SIZE);
        in_bar    = (m_v < `HP_BAR_H) && (m_h < m_hp * `HP_BAR_W);
        if (blank_c) pix_c = int'(game_pkg::C_BLACK);
        else if (m_hp == 0) pix_c = int'(game_pkg::C_RED);  // game over covers the screen
        else if (in_player) pix_c = int'(game_pkg::C_PLAYER);
        else if (in_bar) pix_c = int'(game_pkg::C_HPBAR);
        else pix_c = code;
        px_n  = m_px;
        py_n  = m_py;
        cur_n = m_cur;
        if (m_h == 0 && m_v == 0) begin  // one step per held direction at the frame start
            if (left && !right && m_px > 0) px_n = m_px - 1;
            if (right && !left && m_px < X_MAX) px_n = m_px + 1;
            if (up && !down && m_py > 0) py_n = m_py - 1;
            if (down && !up && m_py < Y_MAX) py_n = m_py + 1;
        end
        if (m_h == m_px && m_v == m_py) cur_n = code;  // sample under the anchor
        st_n   = m_state;
        hp_n   = m_hp;
        hold_n = m_hold;
        case (m_state)
            game_pkg::HP_IDLE: begin
                if (m_cur == int'(game_pkg::C_LAVA)) begin
                    st_n = game_pkg::HP_DEC;
                    if (m_hp > 0) hp_n = m_hp - 1;  // saturates at zero
                end
            end
            game_pkg::HP_DEC: begin
                st_n   = game_pkg::HP_HOLD;
                hold_n = 0;
            end
            game_pkg::HP_HOLD: begin
                if (m_hold == `HP_HOLDOFF) st_n = game_pkg::HP_IDLE;  // HP_HOLDOFF+1 cycles
                else hold_n = m_hold + 1;
            end
            default: st_n = game_pkg::HP_IDLE;
        endcase
        m_pix   = pix_c;
        m_hs    = (m_h >= `H_SYNC_START) && (m_h < `H_SYNC_END);
        m_vs    = (m_v >= `V_SYNC_START) && (m_v < `V_SYNC_END);
        m_blank = blank_c;
        m_px    = px_n;
        m_py    = py_n;
        m_cur   = cur_n;
        m_state = st_n;
        m_hp    = hp_n;
        m_hold  = hold_n;
        if (m_h == `H_TOTAL - 1) begin
            m_h = 0;
            m_v = (m_v == `V_TOTAL - 1) ? 0 : m_v + 1;
        end else begin
            m_h = m_h + 1;
        end
    endtask

    task automatic choose_directions();
        logic [31:0] r;
        if (frame_idx < RANDOM_FRAMES) begin
            r = next_rand();
            if (r[26:24] == 3'd0) begin  // an idle frame now and then
                up    = 1'b0;
                down  = 1'b0;
                left  = 1'b0;
                right = 1'b0;
            end else begin
                up    = r[16];
                down  = r[17];
                left  = r[18];
                right = r[19];
            end
        end else begin
            up    = 1'b0;
            down  = 1'b1;  // keeps pushing against the bottom clamp
            left  = (m_px > TARGET_X);
            right = (m_px < TARGET_X);
        end
    endtask

    task automatic check_outputs();
        compare_value("pix", m_pix, int'(pix));
        compare_value("hsync", int'(m_hs), int'(hsync));
        compare_value("vsync", int'(m_vs), int'(vsync));
        compare_value("blank", int'(m_blank), int'(blank));
        compare_value("hp", m_hp, int'(hp));
        if (int'(hp) != prev_hp) begin
            assert (int'(hp) == prev_hp - 1) else
                report_problem("hit points changed by something other than one step down");
            if (drops > 0) begin
                assert (cyc - last_drop >= `HP_HOLDOFF + 3) else
                    report_problem("a second hit point was taken inside the hold-off");
            end
            last_drop = cyc;
            drops     = drops + 1;
            prev_hp   = int'(hp);
        end
        if (hp_seen == 0 && !blank) begin
            assert (pix == 4'(game_pkg::C_RED)) else
                report_problem("an active pixel is not red after the game is over");
        end
        hp_seen = int'(hp);
    endtask

    initial begin
        seed      = 32'd41;
        rst       = 1'b1;
        up        = 1'b0;
        down      = 1'b0;
        left      = 1'b0;
        right     = 1'b0;
        frame_idx = 0;
        cyc       = 0;
        prev_hp   = `HP_INIT;
        hp_seen   = `HP_INIT;
        last_drop = 0;
        drops     = 0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (frame_idx < RUN_FRAMES || m_h != 0 || m_v != 0) begin
            check_outputs();
            if (m_h == 0 && m_v == 0) begin  // next edge is the frame start
                choose_directions();
                frame_idx = frame_idx + 1;
            end
            model_step();
            @(negedge clk);
            cyc = cyc + 1;
        end
        check_outputs();
        assert (hp == 4'd0) else report_problem("hit points never reached zero on lava");
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- common/game_pkg.sv
package game_pkg;

    // states of the hit-point FSM
    typedef enum logic [1:0] {
        HP_IDLE = 2'd0,  // armed, waiting for a lava sample
        HP_DEC  = 2'd1,  // one point was just taken
        HP_HOLD = 2'd2   // hold-off window, lava is ignored here
    } hp_state_t;

    // four-bit colour codes carried through the pixel path
    typedef enum logic [3:0] {
        C_BLACK  = 4'd0,   // blanking interval
        C_RED    = 4'd1,   // game over fill
        C_GRASS  = 4'd2,   // even tile rows
        C_SAND   = 4'd4,   // odd tile rows
        C_LAVA   = 4'd5,   // hazard tile
        C_HPBAR  = 4'd12,  // hit-point bar in the top left corner
        C_PLAYER = 4'd15   // player square
    } pix_code_t;

    // the RGB mapping of these codes happens outside this design

endpackage

//--- common/game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// horizontal scan, in pixel clock counts
`define H_ACTIVE      64
`define H_TOTAL       80
`define H_SYNC_START  68
`define H_SYNC_END    74

// vertical scan, in line counts
`define V_ACTIVE      48
`define V_TOTAL       52
`define V_SYNC_START  49
`define V_SYNC_END    50

`define TILE_SHIFT    3     // tiles are 8 by 8 pixels
`define PLAYER_SIZE   4     // side of the player square

`define HP_INIT       9     // hit points after reset
`define HP_HOLDOFF    2000  // cycles of immunity after a hit
`define HP_BAR_W      4     // bar pixels per hit point
`define HP_BAR_H      4     // bar height in rows

`define PLAYER_X0     32    // anchor after reset
`define PLAYER_Y0     24

`endif

//--- hp/control_hp.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module control_hp (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] current_pix,
    output logic [3:0] hp_numb
);

    localparam int TW = $clog2(`HP_HOLDOFF + 1);  // wide enough to reach the hold-off value

    game_pkg::hp_state_t state;
    game_pkg::hp_state_t state_nxt;
    logic [3:0]          hp_numb_nxt;
    logic [TW-1:0]       timer;
    logic [TW-1:0]       timer_nxt;
    logic                lava;
    logic                hold_done;

    assign lava      = (current_pix == game_pkg::C_LAVA);
    assign hold_done = (timer == TW'(`HP_HOLDOFF));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= game_pkg::HP_IDLE;
            hp_numb <= 4'(`HP_INIT);
            timer   <= '0;
        end else begin
            state   <= state_nxt;
            hp_numb <= hp_numb_nxt;
            timer   <= timer_nxt;
        end
    end

    always_comb begin
        case (state)
            game_pkg::HP_IDLE: state_nxt = lava ? game_pkg::HP_DEC : game_pkg::HP_IDLE;
            game_pkg::HP_DEC:  state_nxt = game_pkg::HP_HOLD;  // single cycle state
            game_pkg::HP_HOLD: state_nxt = hold_done ? game_pkg::HP_IDLE : game_pkg::HP_HOLD;
            default:           state_nxt = game_pkg::HP_IDLE;
        endcase
    end

    // the point is taken on the edge that leaves idle, so it shows one cycle after the sample
    always_comb begin
        hp_numb_nxt = hp_numb;
        timer_nxt   = '0;  // timer rests at zero outside the hold window
        if ((state_nxt == game_pkg::HP_DEC) && (hp_numb != 4'd0)) begin
            hp_numb_nxt = hp_numb - 1'b1;  // stops at zero
        end
        if ((state == game_pkg::HP_HOLD) && (state_nxt == game_pkg::HP_HOLD)) begin
            timer_nxt = timer + 1'b1;  // hold lasts HP_HOLDOFF+1 cycles counting from zero
        end
    end

endmodule

//--- sim.f
+incdir+common
common/game_pkg.sv
src/vga_timing.sv
src/player_ctrl.sv
src/playfield.sv
hp/control_hp.sv
src/hud_overlay.sv
src/game_top.sv
bench/game_tb.sv

//--- src/game_top.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module game_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       up,
    input  logic       down,
    input  logic       left,
    input  logic       right,
    output logic [3:0] pix,
    output logic       hsync,
    output logic       vsync,
    output logic       blank,
    output logic [3:0] hp
);

    logic [$clog2(`H_TOTAL)-1:0] hcount;
    logic [$clog2(`V_TOTAL)-1:0] vcount;
    logic [$clog2(`H_TOTAL)-1:0] player_x;
    logic [$clog2(`V_TOTAL)-1:0] player_y;
    logic                        tim_hsync;    // raw syncs before the output stage
    logic                        tim_vsync;
    logic                        tim_blank;
    logic                        frame_start;
    game_pkg::pix_code_t         field_pix;
    logic [3:0]                  current_pix;  // tile code under the anchor

    vga_timing u_vga_timing (
        .clk(clk), .rst(rst), .hcount(hcount), .vcount(vcount), .hsync(tim_hsync),
        .vsync(tim_vsync), .blank(tim_blank), .frame_start(frame_start)
    );

    player_ctrl u_player_ctrl (
        .clk(clk), .rst(rst), .frame_start(frame_start), .up(up), .down(down),
        .left(left), .right(right), .player_x(player_x), .player_y(player_y)
    );

    playfield u_playfield (
        .clk(clk), .rst(rst), .hcount(hcount), .vcount(vcount), .player_x(player_x),
        .player_y(player_y), .field_pix(field_pix), .current_pix(current_pix)
    );

    control_hp u_control_hp (
        .clk(clk), .rst(rst), .current_pix(current_pix), .hp_numb(hp)
    );

    hud_overlay u_hud_overlay (
        .clk(clk), .rst(rst), .hcount(hcount), .vcount(vcount), .player_x(player_x),
        .player_y(player_y), .field_pix(field_pix), .hp_numb(hp), .blank(tim_blank),
        .hsync(tim_hsync), .vsync(tim_vsync), .pix(pix), .hsync_out(hsync),
        .vsync_out(vsync), .blank_out(blank)
    );

endmodule

//--- src/hud_overlay.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module hud_overlay (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [$clog2(`H_TOTAL)-1:0] hcount,
    input  logic [$clog2(`V_TOTAL)-1:0] vcount,
    input  logic [$clog2(`H_TOTAL)-1:0] player_x,
    input  logic [$clog2(`V_TOTAL)-1:0] player_y,
    input  game_pkg::pix_code_t         field_pix,
    input  logic [3:0]                  hp_numb,
    input  logic                        blank,
    input  logic                        hsync,
    input  logic                        vsync,
    output logic [3:0]                  pix,
    output logic                        hsync_out,
    output logic                        vsync_out,
    output logic                        blank_out
);

    localparam int HW = $clog2(`H_TOTAL);
    localparam int VW = $clog2(`V_TOTAL);

    logic [HW:0]         player_x_end;  // one past the right edge, extra bit against overflow
    logic [VW:0]         player_y_end;
    logic [HW:0]         bar_len;       // bar length in pixels
    logic                in_player;
    logic                in_bar;
    game_pkg::pix_code_t pix_nxt;

    assign player_x_end = {1'b0, player_x} + (HW + 1)'(`PLAYER_SIZE);
    assign player_y_end = {1'b0, player_y} + (VW + 1)'(`PLAYER_SIZE);
    assign bar_len      = (HW + 1)'(hp_numb) * (HW + 1)'(`HP_BAR_W);

    assign in_player = (hcount >= player_x) && ({1'b0, hcount} < player_x_end) &&
                       (vcount >= player_y) && ({1'b0, vcount} < player_y_end);
    assign in_bar    = (vcount < VW'(`HP_BAR_H)) && ({1'b0, hcount} < bar_len);

    always_comb begin
        if (blank) begin
            pix_nxt = game_pkg::C_BLACK;
        end else if (hp_numb == 4'd0) begin
            pix_nxt = game_pkg::C_RED;  // game over covers everything
        end else if (in_player) begin
            pix_nxt = game_pkg::C_PLAYER;
        end else if (in_bar) begin
            pix_nxt = game_pkg::C_HPBAR;
        end else begin
            pix_nxt = field_pix;
        end
    end

    // syncs pass through the same register stage as the pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            pix       <= game_pkg::C_BLACK;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            blank_out <= 1'b1;  // dark until the first real pixel
        end else begin
            pix       <= pix_nxt;
            hsync_out <= hsync;
            vsync_out <= vsync;
            blank_out <= blank;
        end
    end

endmodule

//--- src/player_ctrl.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module player_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        frame_start,
    input  logic                        up,
    input  logic                        down,
    input  logic                        left,
    input  logic                        right,
    output logic [$clog2(`H_TOTAL)-1:0] player_x,
    output logic [$clog2(`V_TOTAL)-1:0] player_y
);

    localparam int HW    = $clog2(`H_TOTAL);
    localparam int VW    = $clog2(`V_TOTAL);
    localparam int X_MAX = `H_ACTIVE - `PLAYER_SIZE;  // keeps the right edge on screen
    localparam int Y_MAX = `V_ACTIVE - `PLAYER_SIZE;  // keeps the bottom edge on screen

    logic [HW-1:0] x_nxt;
    logic [VW-1:0] y_nxt;

    // opposite directions cancel, a step past a limit is dropped
    always_comb begin
        x_nxt = player_x;
        y_nxt = player_y;
        if (left && !right && (player_x != '0)) begin
            x_nxt = player_x - 1'b1;
        end else if (right && !left && (player_x < HW'(X_MAX))) begin
            x_nxt = player_x + 1'b1;
        end
        if (up && !down && (player_y != '0)) begin
            y_nxt = player_y - 1'b1;  // screen y grows downwards
        end else if (down && !up && (player_y < VW'(Y_MAX))) begin
            y_nxt = player_y + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            player_x <= HW'(`PLAYER_X0);
            player_y <= VW'(`PLAYER_Y0);
        end else if (frame_start) begin
            player_x <= x_nxt;  // only one step per frame
            player_y <= y_nxt;
        end
    end

endmodule

//--- src/playfield.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module playfield (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [$clog2(`H_TOTAL)-1:0] hcount,
    input  logic [$clog2(`V_TOTAL)-1:0] vcount,
    input  logic [$clog2(`H_TOTAL)-1:0] player_x,
    input  logic [$clog2(`V_TOTAL)-1:0] player_y,
    output game_pkg::pix_code_t         field_pix,
    output logic [3:0]                  current_pix
);

    localparam int HW = $clog2(`H_TOTAL);
    localparam int VW = $clog2(`V_TOTAL);

    logic [HW-1:0] tile_x;      // column of 8 pixel tiles
    logic [VW-1:0] tile_y;      // row of 8 pixel tiles
    logic [1:0]    tile_mix;    // decides where lava goes
    logic          anchor_hit;  // scan is at the player anchor

    assign tile_x   = hcount >> `TILE_SHIFT;
    assign tile_y   = vcount >> `TILE_SHIFT;
    assign tile_mix = tile_x[1:0] ^ tile_y[1:0];

    // lava forms a diagonal stripe pattern, the rest alternates by row
    always_comb begin
        if (tile_mix == 2'b11) begin
            field_pix = game_pkg::C_LAVA;
        end else if (tile_y[0]) begin
            field_pix = game_pkg::C_SAND;  // odd rows
        end else begin
            field_pix = game_pkg::C_GRASS;
        end
    end

    assign anchor_hit = (hcount == player_x) && (vcount == player_y);

    // the anchor is passed once per frame so the sample holds a whole frame
    always_ff @(posedge clk) begin
        if (rst) begin
            current_pix <= game_pkg::C_GRASS;  // start out as safe ground
        end else if (anchor_hit) begin
            current_pix <= field_pix;
        end
    end

endmodule

//--- src/vga_timing.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module vga_timing (
    input  logic                        clk,
    input  logic                        rst,
    output logic [$clog2(`H_TOTAL)-1:0] hcount,
    output logic [$clog2(`V_TOTAL)-1:0] vcount,
    output logic                        hsync,
    output logic                        vsync,
    output logic                        blank,
    output logic                        frame_start
);

    localparam int HW = $clog2(`H_TOTAL);  // 7 bits for an 80 count line
    localparam int VW = $clog2(`V_TOTAL);  // 6 bits for 52 lines

    logic h_wrap;  // last pixel of the line
    logic v_wrap;  // last line of the frame

    assign h_wrap = (hcount == HW'(`H_TOTAL - 1));
    assign v_wrap = (vcount == VW'(`V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;  // scan restarts at the top left corner
            vcount <= '0;
        end else begin
            if (h_wrap) begin
                hcount <= '0;
                if (v_wrap) begin
                    vcount <= '0;  // frame done
                end else begin
                    vcount <= vcount + 1'b1;  // next line
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // sync windows are half open, start included and end excluded
    assign hsync = (hcount >= HW'(`H_SYNC_START)) && (hcount < HW'(`H_SYNC_END));
    assign vsync = (vcount >= VW'(`V_SYNC_START)) && (vcount < VW'(`V_SYNC_END));

    assign blank = (hcount >= HW'(`H_ACTIVE)) || (vcount >= VW'(`V_ACTIVE));  // outside picture

    assign frame_start = (hcount == '0) && (vcount == '0);  // one cycle per frame

endmodule
